// File: hw/oflow_config.svh
`ifndef OFLOW_CONFIG_SVH
`define OFLOW_CONFIG_SVH

// ------------------------------------------------------------
// feature field widths
// ------------------------------------------------------------
`define OFLOW_COORD_LEN  8   // one box corner coordinate
`define OFLOW_SIZE_LEN   8   // box width / height
`define OFLOW_COLOR_LEN  24  // packed rgb colour value
`define OFLOW_HIST_LEN   3   // history depth of a record

// ------------------------------------------------------------
// score arithmetic
// ------------------------------------------------------------
`define OFLOW_WEIGHT_LEN 4   // unsigned weight per term
`define OFLOW_FRAC_BITS  10  // q.10 fixed point, 1024 == 1.0
`define OFLOW_SCORE_LEN  40  // room for six weighted q24.10 terms

// ------------------------------------------------------------
// history store
// ------------------------------------------------------------
`define OFLOW_NUM_OBJ    8   // stored records
`define OFLOW_ID_LEN     3   // log2 of record count

`endif

// File: hw/oflow_pkg.sv
`include "oflow_config.svh"

package oflow_pkg;

	// plain vectors for the widths with a meaning
	typedef logic [`OFLOW_COORD_LEN-1:0]  coord_t;
	typedef logic [`OFLOW_SIZE_LEN-1:0]   size_t;
	typedef logic [`OFLOW_COLOR_LEN-1:0]  color_t;
	typedef logic [`OFLOW_HIST_LEN-1:0]   hist_t;
	typedef logic [`OFLOW_WEIGHT_LEN-1:0] weight_t;
	typedef logic [`OFLOW_SCORE_LEN-1:0]  score_t;
	typedef logic [`OFLOW_ID_LEN-1:0]     id_t;
	typedef logic [`OFLOW_FRAC_BITS:0]    iou_t;  // q0.10, 1024 is a full overlap

	// bounding box, corners in msb-first order
	typedef struct packed {
		coord_t x_tl;
		coord_t y_tl;
		coord_t x_br;
		coord_t y_br;
	} position_t;

	// one tracked object record, 99 bits
	typedef struct packed {
		position_t pos;
		size_t     width;
		size_t     height;
		color_t    color1;
		color_t    color2;
		hist_t     hist;
	} feature_t;

	typedef enum logic [1:0] {idle_st, calc_st, sum_st} metric_state_t;
	typedef enum logic [1:0] {wait_req_st, busy_st, ack_st} hs_state_t;

endpackage

// File: hw/oflow_feature_if.sv
`timescale 1ns/1ps

// history buffer -> similarity metric
interface oflow_feature_if import oflow_pkg::*; ();
	logic     start;          // one entry ready to be scored
	feature_t prev_features;  // the stored record
	id_t      entry_id;
	logic     last;           // final entry of this request
	logic     read_next;      // metric asks for the next record

	modport source (output start, prev_features, entry_id, last, input read_next);
	modport sink   (input start, prev_features, entry_id, last, output read_next);
endinterface

// similarity metric -> match selector
interface oflow_score_if import oflow_pkg::*; ();
	logic   valid;     // single-cycle pulse per entry
	score_t score;
	id_t    entry_id;
	logic   last;
	logic   first;     // entry 0, restarts the minimum search

	modport source (output valid, score, entry_id, last, first);
	modport sink   (input valid, score, entry_id, last, first);
endinterface

// File: hw/oflow_calc_iou.sv
`timescale 1ns/1ps
`include "oflow_config.svh"

module oflow_calc_iou
	import oflow_pkg::*;
(
	input  logic      clk,
	input  logic      reset_N,
	input  logic      start,
	input  position_t box_cur,
	input  position_t box_prev,
	input  size_t     w_cur,
	input  size_t     h_cur,
	input  size_t     w_prev,
	input  size_t     h_prev,
	output logic      valid_iou,
	output iou_t      iou
);

	localparam int AREA_LEN  = 2 * `OFLOW_SIZE_LEN;
	localparam int UNI_LEN   = AREA_LEN + 1;        // sum of two areas
	localparam int DIV_STEPS = `OFLOW_FRAC_BITS + 1; // one quotient bit each

	coord_t x_lo, x_hi, y_lo, y_hi;       // overlap corners
	size_t  ov_w_q, ov_h_q;
	logic [AREA_LEN-1:0] area_cur_q, area_prev_q, inter;
	logic [UNI_LEN-1:0]  uni, uni_q, rem_q;
	logic [UNI_LEN:0]    trial;
	logic [`OFLOW_FRAC_BITS:0] num_q;     // low dividend bits still to shift in
	iou_t quo_q;
	logic q_bit;
	logic uni_zero_q;
	logic s1_q, div_busy;
	logic [3:0] step_cnt;

	// ------------------------------------------------------------
	// overlap box and union
	// ------------------------------------------------------------
	assign x_lo = (box_cur.x_tl > box_prev.x_tl) ? box_cur.x_tl : box_prev.x_tl;
	assign x_hi = (box_cur.x_br < box_prev.x_br) ? box_cur.x_br : box_prev.x_br;
	assign y_lo = (box_cur.y_tl > box_prev.y_tl) ? box_cur.y_tl : box_prev.y_tl;
	assign y_hi = (box_cur.y_br < box_prev.y_br) ? box_cur.y_br : box_prev.y_br;

	assign inter = ov_w_q * ov_h_q;
	assign uni   = area_cur_q + area_prev_q - inter;

	// restoring step, next dividend bit appended to the remainder
	assign trial = {rem_q, num_q[`OFLOW_FRAC_BITS]};
	assign q_bit = (trial >= {1'b0, uni_q});

	assign iou = uni_zero_q ? '0 : quo_q;  // empty union gives no overlap

	// ------------------------------------------------------------
	// sequencing, 2 area cycles then DIV_STEPS divider cycles
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			s1_q      <= 1'b0;
			div_busy  <= 1'b0;
			step_cnt  <= '0;
			valid_iou <= 1'b0;
		end else begin
			valid_iou <= 1'b0;
			s1_q      <= start;
			if (s1_q) begin
				div_busy <= 1'b1;
				step_cnt <= 4'(DIV_STEPS);
			end else if (div_busy) begin
				step_cnt <= step_cnt - 4'd1;
				if (step_cnt == 4'd1) begin  // last quotient bit this edge
					div_busy  <= 1'b0;
					valid_iou <= 1'b1;
				end
			end
		end
	end

	// datapath
	always_ff @(posedge clk) begin
		if (start) begin
			ov_w_q      <= (x_hi > x_lo) ? size_t'(x_hi - x_lo) : '0;  // clamp at 0
			ov_h_q      <= (y_hi > y_lo) ? size_t'(y_hi - y_lo) : '0;
			area_cur_q  <= w_cur * h_cur;    // sizes from fields, not corners
			area_prev_q <= w_prev * h_prev;
		end
		if (s1_q) begin
			// dividend is inter << 10, top part preloaded into the remainder
			uni_q      <= uni;
			uni_zero_q <= (uni == '0);
			rem_q      <= UNI_LEN'(inter >> 1);
			num_q      <= {inter[0], {`OFLOW_FRAC_BITS{1'b0}}};
		end else if (div_busy) begin
			rem_q <= q_bit ? UNI_LEN'(trial - {1'b0, uni_q}) : trial[UNI_LEN-1:0];
			num_q <= num_q << 1;
			quo_q <= {quo_q[`OFLOW_FRAC_BITS-1:0], q_bit};
		end
	end

endmodule

// File: hw/oflow_history_buffer.sv
`timescale 1ns/1ps
`include "oflow_config.svh"

module oflow_history_buffer
	import oflow_pkg::*;
(
	input  logic     clk,
	input  logic     reset_N,
	input  logic     wr_en,
	input  id_t      wr_addr,
	input  feature_t wr_data,
	input  logic     req,
	input  logic     ack,
	input  logic     done,      // metric valid, one entry scored
	oflow_feature_if.source feat
);

	feature_t mem [`OFLOW_NUM_OBJ];

	id_t  ptr;
	logic req_q;
	logic busy;       // walking the records
	logic launch_q;   // first start one cycle after the request
	logic final_q;    // last entry already handed out
	logic new_req;
	logic last_entry;

	// ------------------------------------------------------------
	// record memory, host write port
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	assign feat.prev_features = mem[ptr];
	assign feat.entry_id      = ptr;
	assign last_entry         = (ptr == id_t'(`OFLOW_NUM_OBJ - 1));
	assign feat.last          = last_entry;

	// rising req, only between transactions
	assign new_req = req & ~req_q & ~ack & ~busy;

	// ------------------------------------------------------------
	// read sequencer
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			req_q      <= 1'b0;
			busy       <= 1'b0;
			launch_q   <= 1'b0;
			final_q    <= 1'b0;
			ptr        <= '0;
			feat.start <= 1'b0;
		end else begin
			req_q    <= req;
			launch_q <= new_req;
			feat.start <= launch_q | (done & busy & ~final_q);  // next entry after valid
			if (new_req) begin
				busy    <= 1'b1;
				final_q <= 1'b0;
				ptr     <= '0;
			end else begin
				if (feat.read_next) begin
					if (last_entry)
						final_q <= 1'b1;   // hold ptr on the final record
					else
						ptr <= ptr + id_t'(1);
				end
				if (done && final_q)
					busy <= 1'b0;   // whole history scored
			end
		end
	end

endmodule

// File: hw/oflow_similarity_metric.sv
`timescale 1ns/1ps
`include "oflow_config.svh"

module oflow_similarity_metric
	import oflow_pkg::*;
(
	input  logic     clk,
	input  logic     reset_N,
	input  weight_t  iou_weight,
	input  weight_t  w_weight,
	input  weight_t  h_weight,
	input  weight_t  color1_weight,
	input  weight_t  color2_weight,
	input  weight_t  hist_weight,
	input  feature_t cur_features,
	oflow_feature_if.sink   feat,
	oflow_score_if.source   res
);

	localparam int HIST_TERM_LEN = 1 << `OFLOW_HIST_LEN;  // 1 << hist fits here

	metric_state_t state, next_state;

	logic start_iou;
	logic valid_iou;
	iou_t iou, iou_q;

	size_t  w_dist_q, h_dist_q;
	color_t c1_dist_q, c2_dist_q;
	logic [HIST_TERM_LEN-1:0] hist_term_q;
	id_t  id_q;
	logic last_q;

	score_t iou_term, w_term, h_term, c1_term, c2_term, hist_term;

	// ------------------------------------------------------------
	// iou of current box against the stored one
	// ------------------------------------------------------------
	oflow_calc_iou i_calc_iou (
		.clk       (clk),
		.reset_N   (reset_N),
		.start     (start_iou),
		.box_cur   (cur_features.pos),
		.box_prev  (feat.prev_features.pos),
		.w_cur     (cur_features.width),
		.h_cur     (cur_features.height),
		.w_prev    (feat.prev_features.width),
		.h_prev    (feat.prev_features.height),
		.valid_iou (valid_iou),
		.iou       (iou)
	);

	// ------------------------------------------------------------
	// fsm
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state     <= idle_st;
			start_iou <= 1'b0;
		end else begin
			state     <= next_state;
			start_iou <= (state == idle_st) && feat.start;  // one cycle behind start
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			idle_st: if (feat.start) next_state = calc_st;
			calc_st: if (valid_iou) next_state = sum_st;
			sum_st:  next_state = idle_st;
			default: next_state = idle_st;
		endcase
	end

	// prefetch the next record two cycles before its start
	assign feat.read_next = (state == calc_st) && valid_iou;

	// ------------------------------------------------------------
	// distance terms, refreshed while the iou runs
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (state == idle_st && feat.start) begin
			id_q   <= feat.entry_id;   // pointer moves before valid
			last_q <= feat.last;
		end
		if (state == calc_st) begin
			w_dist_q    <= size_t'(l1_dist(color_t'(feat.prev_features.width),
				color_t'(cur_features.width)));
			h_dist_q    <= size_t'(l1_dist(color_t'(feat.prev_features.height),
				color_t'(cur_features.height)));
			c1_dist_q   <= l1_dist(feat.prev_features.color1, cur_features.color1);
			c2_dist_q   <= l1_dist(feat.prev_features.color2, cur_features.color2);
			hist_term_q <= {{(HIST_TERM_LEN-1){1'b0}}, 1'b1} << feat.prev_features.hist;
			if (valid_iou)
				iou_q <= iou;
		end
	end

	// ------------------------------------------------------------
	// weighted score, q.10
	// ------------------------------------------------------------
	assign iou_term  = score_t'(iou_weight) *
		((score_t'(1) << `OFLOW_FRAC_BITS) - score_t'(iou_q));  // 1 - iou
	assign w_term    = score_t'(w_weight) * (score_t'(w_dist_q) << `OFLOW_FRAC_BITS);
	assign h_term    = score_t'(h_weight) * (score_t'(h_dist_q) << `OFLOW_FRAC_BITS);
	assign c1_term   = score_t'(color1_weight) * (score_t'(c1_dist_q) << `OFLOW_FRAC_BITS);
	assign c2_term   = score_t'(color2_weight) * (score_t'(c2_dist_q) << `OFLOW_FRAC_BITS);
	assign hist_term = score_t'(hist_weight) * (score_t'(hist_term_q) << `OFLOW_FRAC_BITS);

	assign res.score    = iou_term + w_term + h_term + c1_term + c2_term + hist_term;
	assign res.valid    = (state == sum_st);
	assign res.entry_id = id_q;
	assign res.last     = last_q;
	assign res.first    = (id_q == '0);

	// absolute difference, widest field
	function automatic color_t l1_dist(input color_t a, input color_t b);
		l1_dist = (a > b) ? (a - b) : (b - a);
	endfunction

endmodule

// File: hw/oflow_match_selector.sv
`timescale 1ns/1ps

module oflow_match_selector
	import oflow_pkg::*;
(
	input  logic   clk,
	input  logic   reset_N,
	input  logic   req,
	oflow_score_if.sink res,
	output logic   ack,
	output id_t    best_id,
	output score_t best_score
);

	hs_state_t state;

	// ------------------------------------------------------------
	// running minimum
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		// strict compare keeps the lower id on a tie
		if (res.valid && (res.first || res.score < best_score)) begin
			best_score <= res.score;
			best_id    <= res.entry_id;
		end
	end

	// ------------------------------------------------------------
	// four-phase ack side
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= wait_req_st;
		end else begin
			case (state)
				wait_req_st: if (req) state <= busy_st;
				busy_st:     if (res.valid && res.last) state <= ack_st;  // result settled
				ack_st:      if (!req) state <= wait_req_st;               // host released
				default:     state <= wait_req_st;
			endcase
		end
	end

	assign ack = (state == ack_st);

endmodule

// File: hw/oflow_tracker_top.sv
`timescale 1ns/1ps

module oflow_tracker_top
	import oflow_pkg::*;
(
	input  logic     clk,
	input  logic     reset_N,
	// history write port
	input  logic     wr_en,
	input  id_t      wr_addr,
	input  feature_t wr_data,
	// request side
	input  logic     req,
	input  feature_t cur_features,
	input  weight_t  iou_weight,
	input  weight_t  w_weight,
	input  weight_t  h_weight,
	input  weight_t  color1_weight,
	input  weight_t  color2_weight,
	input  weight_t  hist_weight,
	// result
	output logic     ack,
	output id_t      best_id,
	output score_t   best_score
);

	oflow_feature_if feat_if ();
	oflow_score_if   score_if ();

	// ------------------------------------------------------------
	// record store and sequencer
	// ------------------------------------------------------------
	oflow_history_buffer i_history_buffer (
		.clk     (clk),
		.reset_N (reset_N),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.req     (req),
		.ack     (ack),
		.done    (score_if.valid),  // scored entry frees the next start
		.feat    (feat_if.source)
	);

	// per-entry score
	oflow_similarity_metric i_similarity_metric (
		.clk           (clk),
		.reset_N       (reset_N),
		.iou_weight    (iou_weight),
		.w_weight      (w_weight),
		.h_weight      (h_weight),
		.color1_weight (color1_weight),
		.color2_weight (color2_weight),
		.hist_weight   (hist_weight),
		.cur_features  (cur_features),
		.feat          (feat_if.sink),
		.res           (score_if.source)
	);

	// best match and handshake
	oflow_match_selector i_match_selector (
		.clk        (clk),
		.reset_N    (reset_N),
		.req        (req),
		.res        (score_if.sink),
		.ack        (ack),
		.best_id    (best_id),
		.best_score (best_score)
	);

endmodule

// File: testbench/oflow_tb.sv
`timescale 1ns/1ps
`include "oflow_config.svh"

module oflow_tb
	import oflow_pkg::*;
();

	localparam int NUM     = `OFLOW_NUM_OBJ;
	localparam int REQ_LAT = NUM * 16 + 2;     // req to ack in cycles
	localparam int N_REQ   = 9;                // requests over all tests
	localparam int N_LOAD  = 5;                // history loads
	localparam int MAX_CYC = N_REQ * 140 + N_LOAD * (NUM + 1) + 200;

	logic     clk;
	logic     reset_N;
	logic     wr_en;
	id_t      wr_addr;
	feature_t wr_data;
	logic     req;
	feature_t cur_features;
	weight_t  iou_weight, w_weight, h_weight;
	weight_t  color1_weight, color2_weight, hist_weight;
	logic     ack;
	id_t      best_id;
	score_t   best_score;

	feature_t    hist_mem [NUM];   // host copy of the record store
	logic [31:0] rng_state;
	int          mismatch_cnt = 0;
	int          fail_cnt = 0;
	int          cycle_cnt = 0;
	id_t         got_id, exp_id;
	score_t      got_score, exp_score;

	oflow_tracker_top i_dut (
		.clk           (clk),
		.reset_N       (reset_N),
		.wr_en         (wr_en),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.req           (req),
		.cur_features  (cur_features),
		.iou_weight    (iou_weight),
		.w_weight      (w_weight),
		.h_weight      (h_weight),
		.color1_weight (color1_weight),
		.color2_weight (color2_weight),
		.hist_weight   (hist_weight),
		.ack           (ack),
		.best_id       (best_id),
		.best_score    (best_score)
	);

	always #2 clk = ~clk;

	// run limit
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYC) begin
			$display("timeout: no end of run after %0d cycles", MAX_CYC);
			$display("Test failures found");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// stimulus helpers
	// ------------------------------------------------------------
	function automatic logic [31:0] xorshift32();
		logic [31:0] s;
		s = rng_state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		rng_state = s;
		return s;
	endfunction

	// box from corner and size, colours and history random
	function automatic feature_t make_feature(input int x, input int y, input int w, input int h);
		feature_t f;
		f.pos.x_tl = coord_t'(x);
		f.pos.y_tl = coord_t'(y);
		f.pos.x_br = coord_t'(x + w);
		f.pos.y_br = coord_t'(y + h);
		f.width    = size_t'(w);
		f.height   = size_t'(h);
		f.color1   = color_t'(xorshift32());
		f.color2   = color_t'(xorshift32());
		f.hist     = hist_t'(xorshift32());
		return f;
	endfunction

	function automatic feature_t random_feature();
		int x, y;
		x = int'(xorshift32() % 200);
		y = int'(xorshift32() % 200);   // corners stay below 255
		return make_feature(x, y, 1 + int'(xorshift32() % 55), 1 + int'(xorshift32() % 55));
	endfunction

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------
	function automatic longint abs_diff(input longint a, input longint b);
		return (a > b) ? a - b : b - a;
	endfunction

	// q0.10 iou, overlap from corners, areas from size fields
	function automatic longint ref_iou(input feature_t a, input feature_t b);
		longint lo_x, hi_x, lo_y, hi_y, ov_w, ov_h, inter, uni;
		lo_x  = (a.pos.x_tl > b.pos.x_tl) ? a.pos.x_tl : b.pos.x_tl;
		hi_x  = (a.pos.x_br < b.pos.x_br) ? a.pos.x_br : b.pos.x_br;
		lo_y  = (a.pos.y_tl > b.pos.y_tl) ? a.pos.y_tl : b.pos.y_tl;
		hi_y  = (a.pos.y_br < b.pos.y_br) ? a.pos.y_br : b.pos.y_br;
		ov_w  = (hi_x > lo_x) ? hi_x - lo_x : 0;
		ov_h  = (hi_y > lo_y) ? hi_y - lo_y : 0;
		inter = ov_w * ov_h;
		uni   = longint'(a.width) * longint'(a.height)
			+ longint'(b.width) * longint'(b.height) - inter;
		if (uni == 0)
			return 0;
		return (inter * 1024) / uni;
	endfunction

	function automatic score_t ref_score(input feature_t c, input feature_t p);
		longint s;
		s = longint'(iou_weight) * (1024 - ref_iou(c, p));
		s += longint'(w_weight) * abs_diff(c.width, p.width) * 1024;
		s += longint'(h_weight) * abs_diff(c.height, p.height) * 1024;
		s += longint'(color1_weight) * abs_diff(c.color1, p.color1) * 1024;
		s += longint'(color2_weight) * abs_diff(c.color2, p.color2) * 1024;
		s += longint'(hist_weight) * (longint'(1) << p.hist) * 1024;
		return score_t'(s);   // kept to score width
	endfunction

	// lowest score, first index wins a tie
	task automatic find_best();
		score_t s;
		exp_id    = '0;
		exp_score = ref_score(cur_features, hist_mem[0]);
		for (int i = 1; i < NUM; i++) begin
			s = ref_score(cur_features, hist_mem[i]);
			if (s < exp_score) begin
				exp_score = s;
				exp_id    = id_t'(i);
			end
		end
	endtask

	// ------------------------------------------------------------
	// bus tasks
	// ------------------------------------------------------------
	task automatic load_history();
		for (int i = 0; i < NUM; i++) begin
			@(negedge clk);
			wr_en   = 1'b1;
			wr_addr = id_t'(i);
			wr_data = hist_mem[i];
		end
		@(negedge clk);
		wr_en = 1'b0;
	endtask

	task automatic set_weights(input int iw, input int ww, input int hw,
		input int c1w, input int c2w, input int hsw);
		iou_weight    = weight_t'(iw);
		w_weight      = weight_t'(ww);
		h_weight      = weight_t'(hw);
		color1_weight = weight_t'(c1w);
		color2_weight = weight_t'(c2w);
		hist_weight   = weight_t'(hsw);
	endtask

	// full four-phase handshake, result captured while ack is high
	task automatic do_request(input string name);
		int cycles;
		@(negedge clk);
		req    = 1'b1;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!ack && cycles < 2 * REQ_LAT);
		if (!ack) begin
			$display("%s: ack never rose after req was raised", name);
			fail_cnt++;
		end else begin
			if (cycles != REQ_LAT) begin
				$display("mismatch %s: ack latency expected %0d actual %0d",
					name, REQ_LAT, cycles);
				mismatch_cnt++;
			end
			got_id    = best_id;
			got_score = best_score;
			repeat (3) begin   // req still held
				@(negedge clk);
				if (!ack) begin
					$display("%s: ack fell while req was still high", name);
					fail_cnt++;
				end
			end
		end
		req    = 1'b0;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (ack && cycles < 4);
		if (ack) begin
			$display("%s: ack stayed high after req was dropped", name);
			fail_cnt++;
		end
	endtask

	task automatic check_result(input string name, input id_t e_id, input score_t e_score);
		if (got_id !== e_id) begin
			$display("mismatch %s: best_id expected %0d actual %0d", name, e_id, got_id);
			mismatch_cnt++;
		end
		if (got_score !== e_score) begin
			$display("mismatch %s: best_score expected %0d actual %0d", name, e_score, got_score);
			mismatch_cnt++;
		end
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic test_identical();
		for (int i = 0; i < NUM; i++)
			hist_mem[i] = random_feature();
		cur_features      = random_feature();
		cur_features.hist = 3'd2;
		hist_mem[5]       = cur_features;   // full overlap, zero distances
		load_history();
		set_weights(3, 2, 2, 1, 1, 1);
		do_request("identical");
		check_result("identical", id_t'(5),
			score_t'(longint'(hist_weight) * (longint'(1) << cur_features.hist) * 1024));
	endtask

	task automatic test_single_weight();
		int dw [NUM] = '{40, -30, 25, -17, 60, -9, 33, 20};   // entry 5 closest
		cur_features = make_feature(20, 20, 100, 30);
		for (int i = 0; i < NUM; i++)
			hist_mem[i] = make_feature(20, 20, 100 + dw[i], 30);
		load_history();
		set_weights(0, 5, 0, 0, 0, 0);
		do_request("single_weight");
		check_result("single_weight", id_t'(5), score_t'(5 * 9 * 1024));
	endtask

	task automatic test_tie_break();
		for (int i = 0; i < NUM; i++)
			hist_mem[i] = random_feature();
		cur_features = random_feature();
		hist_mem[2]  = cur_features;
		hist_mem[6]  = cur_features;
		load_history();
		set_weights(2, 1, 1, 1, 1, 1);
		do_request("tie_break");
		check_result("tie_break", id_t'(2), ref_score(cur_features, hist_mem[2]));
	endtask

	task automatic test_iou_term();
		cur_features = make_feature(50, 50, 40, 40);
		hist_mem[0]  = make_feature(150, 150, 30, 30);  // disjoint
		hist_mem[1]  = make_feature(70, 70, 40, 40);
		hist_mem[2]  = make_feature(60, 60, 40, 40);
		hist_mem[3]  = make_feature(0, 0, 20, 20);
		hist_mem[4]  = make_feature(90, 50, 40, 40);    // edges touch
		hist_mem[5]  = make_feature(45, 55, 30, 20);
		hist_mem[6]  = make_feature(200, 10, 20, 20);
		hist_mem[7]  = make_feature(55, 40, 40, 40);
		load_history();
		set_weights(7, 0, 0, 0, 0, 0);
		do_request("iou_term");
		find_best();
		check_result("iou_term", exp_id, exp_score);
	endtask

	// two requests back to back on the same history
	task automatic test_handshake();
		cur_features = make_feature(60, 60, 40, 40);
		set_weights(4, 1, 1, 0, 0, 2);
		do_request("handshake_a");
		find_best();
		check_result("handshake_a", exp_id, exp_score);
		cur_features = random_feature();
		set_weights(1, 3, 2, 0, 1, 1);
		do_request("handshake_b");
		find_best();
		check_result("handshake_b", exp_id, exp_score);
	endtask

	task automatic test_random();
		for (int i = 0; i < NUM; i++)
			hist_mem[i] = random_feature();
		load_history();
		for (int r = 0; r < 3; r++) begin
			cur_features = random_feature();
			set_weights(int'(xorshift32() % 16), int'(xorshift32() % 16),
				int'(xorshift32() % 16), int'(xorshift32() % 16),
				int'(xorshift32() % 16), int'(xorshift32() % 16));
			do_request("random");
			find_best();
			check_result("random", exp_id, exp_score);
		end
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		clk          = 1'b0;
		reset_N      = 1'b0;
		wr_en        = 1'b0;
		wr_addr      = '0;
		wr_data      = '0;
		req          = 1'b0;
		cur_features = '0;
		set_weights(0, 0, 0, 0, 0, 0);
		rng_state    = 32'd83397;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset_N = 1'b1;

		test_identical();
		test_single_weight();
		test_tie_break();
		test_iou_term();
		test_handshake();
		test_random();

		@(negedge clk);
		$display("end of run: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+hw
hw/oflow_pkg.sv
hw/oflow_feature_if.sv
hw/oflow_calc_iou.sv
hw/oflow_history_buffer.sv
hw/oflow_similarity_metric.sv
hw/oflow_match_selector.sv
hw/oflow_tracker_top.sv
testbench/oflow_tb.sv
